//--- verilog/fifo_cfg_pkg.sv
`default_nettype none

// sizes of the byte fifo and the vector types that carry them.
package fifo_cfg_pkg;

    localparam int fifo_depth = 8; // number of entries in the storage array.

    localparam int data_width = 8; // one byte per entry.

    localparam int addr_width = 3; // wide enough to address every entry.

    // one stored byte, as it goes into and comes out of the array.
    typedef logic [data_width-1:0] data_t;

    // an entry address, used by both the write and the read pointer.
    typedef logic [addr_width-1:0] addr_t;

    // occupancy from 0 up to fifo_depth inclusive.
    // the extra top bit lets a completely full fifo be told apart from an empty one.
    typedef logic [addr_width:0] count_t;

endpackage : fifo_cfg_pkg

`default_nettype wire

//--- verilog/fifo_status_pkg.sv
`default_nettype none

// request and status bundles that cross the fifo boundary.
package fifo_status_pkg;

    import fifo_cfg_pkg::*;

    // write side: the strobe travels with the byte it writes.
    typedef struct packed {
        logic  en;   // write strobe.
        data_t data; // byte to store when the strobe is accepted.
    } fifo_wr_t;

    // read side, kept as a struct to mirror the write side.
    typedef struct packed {
        logic en; // read strobe.
    } fifo_rd_t;

    // levels and pulses reported back to the writer and the reader.
    typedef struct packed {
        logic full;     // level, no further write is accepted.
        logic empty;    // level, no further read is accepted.
        logic overrun;  // one-cycle pulse after a refused write.
        logic underrun; // one-cycle pulse after a refused read.
    } fifo_status_t;

endpackage : fifo_status_pkg

`default_nettype wire

//--- verilog/fifo_mem.sv
`timescale 1ns/1ns
`default_nettype none

// storage array with one write port and one registered read port.
module fifo_mem (
    input  wire                  clk,
    input  wire                  we,
    input  wire fifo_cfg_pkg::addr_t waddr,
    input  wire fifo_cfg_pkg::data_t wdata,
    input  wire                  re,
    input  wire fifo_cfg_pkg::addr_t raddr,
    output fifo_cfg_pkg::data_t  rdata,
    input  wire                  rst_n
);

    import fifo_cfg_pkg::*;

    data_t mem [fifo_depth]; // payload only, holds no control state.

    // write port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata; // readable from the next edge on.
        end
    end

    // read port.
    // the output register only changes on an accepted read, so the last
    // byte read stays visible while the reader is idle or refused.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr]; // one cycle of read latency.
        end
    end

endmodule : fifo_mem

`default_nettype wire

//--- verilog/fifo_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

// pointers, occupancy and flags for the byte fifo.
module fifo_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           wr_en,
    input  wire                           rd_en,
    output logic                          we,
    output fifo_cfg_pkg::addr_t           waddr,
    output logic                          re,
    output fifo_cfg_pkg::addr_t           raddr,
    output fifo_cfg_pkg::count_t          level,
    output fifo_status_pkg::fifo_status_t status
);

    import fifo_cfg_pkg::*;
    import fifo_status_pkg::*;

    addr_t        wr_ptr_q;   // next entry to write.
    addr_t        rd_ptr_q;   // oldest entry still stored.
    count_t       count_q;    // entries currently stored.
    count_t       count_next;
    fifo_status_t status_q;
    logic         wr_ok;
    logic         rd_ok;

    // advance a pointer by one entry, wrapping past the last one.
    function automatic addr_t ptr_inc(input addr_t ptr);
        addr_t nxt;
        if (ptr == addr_t'(fifo_depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + addr_t'(1);
        end
        return nxt;
    endfunction

    // accept decisions.
    // both strobes are judged against the flags registered at the
    // previous edge, so a write into a full fifo is refused even when a
    // read is accepted at the same edge.
    assign wr_ok = wr_en & ~status_q.full;
    assign rd_ok = rd_en & ~status_q.empty;

    // memory port controls.
    assign we    = wr_ok;
    assign waddr = wr_ptr_q;
    assign re    = rd_ok;
    assign raddr = rd_ptr_q;

    // occupancy for the next cycle.
    always_comb begin
        count_next = count_q;
        case ({wr_ok, rd_ok})
            2'b10: begin
                count_next = count_q + count_t'(1); // write only.
            end
            2'b01: begin
                count_next = count_q - count_t'(1); // read only.
            end
            default: begin
                count_next = count_q; // idle, or a write and a read together.
            end
        endcase
    end

    // pointers.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (rd_ok) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
        end
    end

    // occupancy and levels.
    // full and empty come from the next count, so after an edge they
    // already include every request accepted at that edge.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            count_q        <= '0;
            status_q.full  <= 1'b0;
            status_q.empty <= 1'b1;
        end else begin
            count_q        <= count_next;
            status_q.full  <= (count_next == count_t'(fifo_depth));
            status_q.empty <= (count_next == '0);
        end
    end

    // refusal pulses.
    // a refused strobe changes nothing but its own pulse, which is high
    // for exactly the cycle that follows the refusing edge.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            status_q.overrun  <= 1'b0;
            status_q.underrun <= 1'b0;
        end else begin
            status_q.overrun  <= wr_en & status_q.full;
            status_q.underrun <= rd_en & status_q.empty;
        end
    end

    assign level  = count_q;
    assign status = status_q;

endmodule : fifo_ctrl

`default_nettype wire

//--- verilog/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// synchronous byte fifo, 8 entries, one clock domain.
module sync_fifo (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire fifo_status_pkg::fifo_wr_t wr,
    input  wire fifo_status_pkg::fifo_rd_t rd,
    output fifo_cfg_pkg::data_t           rd_data,
    output fifo_status_pkg::fifo_status_t status,
    output fifo_cfg_pkg::count_t          level
);

    import fifo_cfg_pkg::*;

    // memory port controls from the control block.
    logic  mem_we;
    addr_t mem_waddr;
    logic  mem_re;
    addr_t mem_raddr;

    // pointers, count and flags.
    // only the strobes reach the control block; it never sees the data.
    fifo_ctrl u_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr.en),
        .rd_en  (rd.en),
        .we     (mem_we),
        .waddr  (mem_waddr),
        .re     (mem_re),
        .raddr  (mem_raddr),
        .level  (level),
        .status (status)
    );

    // byte storage.
    // the write byte goes straight in; the control block decides whether
    // it is stored and where.
    fifo_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (wr.data),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (rd_data),
        .rst_n (rst_n)
    );

endmodule : sync_fifo

`default_nettype wire

//--- tests/fifo_checker.sv
`timescale 1ns/1ns
`default_nettype none

// golden queue model of the byte fifo, compared with the DUT every cycle.
module fifo_checker (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire fifo_status_pkg::fifo_wr_t     wr,
    input  wire fifo_status_pkg::fifo_rd_t     rd,
    input  wire fifo_cfg_pkg::data_t           rd_data,
    input  wire fifo_status_pkg::fifo_status_t status,
    input  wire fifo_cfg_pkg::count_t          level,
    output int                                 error_count,
    output int                                 read_count
);

    import fifo_cfg_pkg::*;
    import fifo_status_pkg::*;

    data_t        model_q[$];          // bytes accepted and not yet read.
    count_t       exp_level;
    data_t        exp_rd_data;
    fifo_status_t exp_status;
    logic         model_valid = 1'b0;  // set once the model has seen an edge.
    int           err_cnt = 0;
    int           rd_cnt = 0;

    assign error_count = err_cnt;
    assign read_count  = rd_cnt;

    // the model moves at the rising edge, judging both strobes against
    // the flags it expects from the previous edge.
    always @(posedge clk) begin : model_update
        logic full_before;
        logic empty_before;
        logic wr_ok;
        logic rd_ok;
        full_before  = (model_q.size() == fifo_depth);
        empty_before = (model_q.size() == 0);
        if (rst_n) begin // reset is active high.
            model_q.delete();
            exp_rd_data = '0;
            exp_status  = '{full: 1'b0, empty: 1'b1, overrun: 1'b0, underrun: 1'b0};
        end else begin
            wr_ok = wr.en && !full_before;
            rd_ok = rd.en && !empty_before;
            if (rd_ok) begin
                exp_rd_data = model_q.pop_front(); // oldest byte comes out first.
                rd_cnt++;
            end
            if (wr_ok) begin
                model_q.push_back(wr.data);
            end
            exp_status.overrun  = wr.en && full_before;
            exp_status.underrun = rd.en && empty_before;
            exp_status.full     = (model_q.size() == fifo_depth);
            exp_status.empty    = (model_q.size() == 0);
        end
        exp_level   = count_t'(model_q.size());
        model_valid = 1'b1;
    end

    // outputs are compared at the falling edge, where they are stable.
    always @(negedge clk) begin
        if (model_valid) begin
            if (rd_data !== exp_rd_data) begin
                $display("** Error: rd_data at %0t ns: got 0x%h, expected 0x%h",
                         $time, rd_data, exp_rd_data);
                err_cnt++;
            end
            if (level !== exp_level) begin
                $display("** Error: level at %0t ns: got 0x%h, expected 0x%h",
                         $time, level, exp_level);
                err_cnt++;
            end
            if (status.full !== exp_status.full) begin
                $display("** Error: status.full at %0t ns: got 0x%h, expected 0x%h",
                         $time, status.full, exp_status.full);
                err_cnt++;
            end
            if (status.empty !== exp_status.empty) begin
                $display("** Error: status.empty at %0t ns: got 0x%h, expected 0x%h",
                         $time, status.empty, exp_status.empty);
                err_cnt++;
            end
            if (status.overrun !== exp_status.overrun) begin
                $display("** Error: status.overrun at %0t ns: got 0x%h, expected 0x%h",
                         $time, status.overrun, exp_status.overrun);
                err_cnt++;
            end
            if (status.underrun !== exp_status.underrun) begin
                $display("** Error: status.underrun at %0t ns: got 0x%h, expected 0x%h",
                         $time, status.underrun, exp_status.underrun);
                err_cnt++;
            end
        end
    end

endmodule : fifo_checker

`default_nettype wire

//--- tests/tb_sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// testbench for the synchronous byte fifo.
module tb_sync_fifo;

    import fifo_cfg_pkg::*;
    import fifo_status_pkg::*;

    localparam int unsigned seed         = 32'h7b98a414;
    localparam int          run_cycles   = 2000;
    localparam int          reset_cycles = 10;
    localparam int          wait_limit   = 100; // cycles allowed for any single wait.

    logic         clk;
    logic         rst_n;
    fifo_wr_t     wr;
    fifo_rd_t     rd;
    data_t        rd_data;
    fifo_status_t status;
    count_t       level;
    int           checker_errors;
    int           reads_checked;
    int           tb_errors;
    int           cycle_count;

    sync_fifo i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data),
        .status  (status),
        .level   (level)
    );

    fifo_checker i_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .rd          (rd),
        .rd_data     (rd_data),
        .status      (status),
        .level       (level),
        .error_count (checker_errors),
        .read_count  (reads_checked)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk; // 4 ns period.
        end
    end

    // reset is active high and held for a fixed number of edges.
    task automatic hold_reset();
        int n;
        n = 0;
        rst_n = 1'b1;
        while (n < reset_cycles) begin
            @(posedge clk);
            n++;
        end
        #1;
        rst_n = 1'b0;
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!(status.empty && level == '0) && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!(status.empty && level == '0)) begin
            $display("timed out waiting for reset release: the fifo never reported empty");
            tb_errors++;
        end
    endtask

    // one cycle of stimulus with strobe chances given in percent.
    task automatic drive_cycle(input int wr_pct, input int rd_pct);
        @(posedge clk);
        #1;
        wr.en   = ($urandom_range(99) < wr_pct);
        wr.data = data_t'($urandom);
        rd.en   = ($urandom_range(99) < rd_pct);
        cycle_count++;
    endtask

    task automatic run_phase(input int kind, input int len);
        int wr_pct;
        int rd_pct;
        case (kind)
            0: begin
                wr_pct = 85; // mostly writes so the fifo fills.
                rd_pct = 15;
            end
            1: begin
                wr_pct = 15; // mostly reads so it drains.
                rd_pct = 85;
            end
            2: begin
                wr_pct = 50;
                rd_pct = 50;
            end
            default: begin
                wr_pct = 5;
                rd_pct = 5;
            end
        endcase
        for (int i = 0; i < len; i++) begin
            drive_cycle(wr_pct, rd_pct);
        end
    endtask

    // read until empty so every stored byte is compared with the model.
    task automatic drain_fifo();
        int waited;
        waited = 0;
        @(posedge clk); // the last random strobes are sampled here.
        #1;
        wr = '0;
        while (!status.empty && waited < wait_limit) begin
            rd.en = 1'b1;
            @(posedge clk);
            #1;
            waited++;
        end
        rd.en = 1'b0;
        if (!status.empty) begin
            $display("timed out waiting for the final drain: the fifo never became empty");
            tb_errors++;
        end
    endtask

    initial begin
        int phase;
        int len;
        rst_n       = 1'b1;
        wr          = '0;
        rd          = '0;
        tb_errors   = 0;
        cycle_count = 0;
        void'($urandom(seed));

        hold_reset();
        wait_ready();
        for (int i = 0; i < 4; i++) begin
            drive_cycle(0, 0); // the checker compares the reset values here.
        end

        cycle_count = 0;
        phase = 0;
        while (cycle_count < run_cycles) begin
            len = 20 + int'($urandom_range(40));
            if (len > run_cycles - cycle_count) begin
                len = run_cycles - cycle_count;
            end
            run_phase(phase, len);
            phase = (phase + 1) % 4;
        end

        drain_fifo();
        for (int i = 0; i < 3; i++) begin
            drive_cycle(0, 0);
        end

        $display("errors: checker %0d, testbench %0d (reads checked %0d, cycles %0d)",
                 checker_errors, tb_errors, reads_checked, cycle_count);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_sync_fifo

`default_nettype wire

//--- src.f
verilog/fifo_cfg_pkg.sv
verilog/fifo_status_pkg.sv
verilog/fifo_mem.sv
verilog/fifo_ctrl.sv
verilog/sync_fifo.sv
tests/fifo_checker.sv
tests/tb_sync_fifo.sv

//--- Makefile
# Verilator build and run for the synchronous byte FIFO.

VERILATOR ?= verilator
TOP       ?= tb_sync_fifo
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --binary -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
